// File: design/conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// Datapath geometry
`define CONV_NUM_PE        4       // Output channels per pixel word
`define CONV_LANES         4       // int8 channels per stream word
`define CONV_WORD_W        32      // Stream word width
`define CONV_ACC_W         24      // Accumulator width

// Run limits
`define CONV_MAX_CH_WORDS  16      // 64 input channels
`define CONV_PIX_W         16      // Pixel count width

// Requantization
`define CONV_OUT_SHIFT     4       // Q4 fixed point
`define CONV_RELU6_MAX     96      // 6.0 in Q4

`endif

// File: design/conv_data_pkg.sv
`include "conv_cfg.svh"

package conv_data_pkg;

    // Four int8 lanes, lane 0 in the low byte
    typedef logic [`CONV_WORD_W-1:0] word_t;

    typedef logic signed [`CONV_ACC_W-1:0] acc_t;   // Signed partial sum

    typedef logic [7:0] act_t;                      // ReLU6 output, never negative

    // One weight word per PE for the current channel word
    typedef word_t [`CONV_NUM_PE-1:0] pe_weights_t;

    typedef acc_t [`CONV_NUM_PE-1:0] pe_acc_t;      // One sum per PE

endpackage

// File: design/conv_ctrl_pkg.sv
`include "conv_cfg.svh"

package conv_ctrl_pkg;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,        // Weight stream
        ST_COMPUTE,     // IFM stream
        ST_DRAIN        // Wait for output buffer
    } run_state_t;

    typedef logic [$clog2(`CONV_MAX_CH_WORDS)-1:0] ch_idx_t;
    typedef logic [$clog2(`CONV_MAX_CH_WORDS):0] ch_cnt_t;     // 1 to 16
    typedef logic [`CONV_PIX_W-1:0] pix_cnt_t;

    // One entry per PE per channel word
    typedef logic [$clog2(`CONV_MAX_CH_WORDS * `CONV_NUM_PE)-1:0] wload_idx_t;

endpackage

// File: design/conv_ctrl.sv
`timescale 1ns/1ns
`include "conv_cfg.svh"

module conv_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  conv_ctrl_pkg::ch_cnt_t  ch_words,
    input  conv_ctrl_pkg::pix_cnt_t num_pixels,
    input  logic                    w_valid,
    output logic                    w_ready,
    input  logic                    ifm_valid,
    output logic                    ifm_ready,
    input  logic                    out_full,
    input  logic                    out_empty,
    input  logic                    load_wrap,
    input  logic                    word_wrap,
    input  logic                    pix_wrap,
    output logic                    cnt_clear,
    output logic                    w_step,
    output logic                    ifm_step,
    output logic                    busy,
    output logic                    done
);

    conv_ctrl_pkg::run_state_t state;
    conv_ctrl_pkg::run_state_t state_nxt;
    logic                      params_ok;

    // A run needs at least one channel word and one pixel
    assign params_ok = (ch_words != '0) &&
                       (ch_words <= conv_ctrl_pkg::ch_cnt_t'(`CONV_MAX_CH_WORDS)) &&
                       (num_pixels != '0);

    assign w_step   = w_valid && w_ready;
    assign ifm_step = ifm_valid && ifm_ready;

    always_comb begin
        state_nxt = state;
        w_ready   = 1'b0;
        ifm_ready = 1'b0;
        cnt_clear = 1'b0;
        case (state)
            conv_ctrl_pkg::ST_IDLE: begin
                if (start && params_ok) begin
                    cnt_clear = 1'b1;                       // Samples run sizes
                    state_nxt = conv_ctrl_pkg::ST_LOAD;
                end
            end
            conv_ctrl_pkg::ST_LOAD: begin
                w_ready = 1'b1;
                if (w_step && load_wrap) begin
                    state_nxt = conv_ctrl_pkg::ST_COMPUTE;
                end
            end
            conv_ctrl_pkg::ST_COMPUTE: begin
                ifm_ready = !(word_wrap && out_full);       // Stall the closing word only
                if (ifm_step && word_wrap && pix_wrap) begin
                    state_nxt = conv_ctrl_pkg::ST_DRAIN;
                end
            end
            conv_ctrl_pkg::ST_DRAIN: begin
                if (out_empty) begin
                    state_nxt = conv_ctrl_pkg::ST_IDLE;
                end
            end
            default: state_nxt = conv_ctrl_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= conv_ctrl_pkg::ST_IDLE;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            busy  <= (state_nxt != conv_ctrl_pkg::ST_IDLE);
            done  <= (state == conv_ctrl_pkg::ST_DRAIN) && (state_nxt == conv_ctrl_pkg::ST_IDLE);
        end
    end

    a_one_stream: assert property (@(posedge clk) disable iff (!rst_n)
        !(w_ready && ifm_ready));

endmodule

// File: design/channel_pixel_counter.sv
`timescale 1ns/1ns
`include "conv_cfg.svh"

module channel_pixel_counter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  conv_ctrl_pkg::ch_cnt_t     ch_words,
    input  conv_ctrl_pkg::pix_cnt_t    num_pixels,
    input  logic                       clear,
    input  logic                       w_step,
    input  logic                       ifm_step,
    output conv_ctrl_pkg::wload_idx_t  load_idx,
    output conv_ctrl_pkg::ch_idx_t     word_idx,
    output logic                       first_word,
    output logic                       load_wrap,
    output logic                       word_wrap,
    output logic                       pix_wrap
);

    localparam int LOAD_CMP_W = $bits(conv_ctrl_pkg::wload_idx_t) + 1;

    conv_ctrl_pkg::ch_cnt_t  ch_words_q;
    conv_ctrl_pkg::pix_cnt_t num_pix_q;
    conv_ctrl_pkg::pix_cnt_t pix_idx;
    logic [LOAD_CMP_W-1:0]   load_last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ch_words_q <= conv_ctrl_pkg::ch_cnt_t'(1);
            num_pix_q  <= conv_ctrl_pkg::pix_cnt_t'(1);
            load_idx   <= '0;
            word_idx   <= '0;
            pix_idx    <= '0;
        end else if (clear) begin
            ch_words_q <= ch_words;
            num_pix_q  <= num_pixels;
            load_idx   <= '0;
            word_idx   <= '0;
            pix_idx    <= '0;
        end else begin
            if (w_step) begin
                load_idx <= load_idx + 1'b1;
            end
            if (ifm_step) begin
                if (word_wrap) begin
                    word_idx <= '0;
                    pix_idx  <= pix_idx + 1'b1;      // Next pixel
                end else begin
                    word_idx <= word_idx + 1'b1;
                end
            end
        end
    end

    assign load_last  = LOAD_CMP_W'(ch_words_q * `CONV_NUM_PE) - 1'b1;
    assign load_wrap  = ({1'b0, load_idx} == load_last);
    assign word_wrap  = ({1'b0, word_idx} == ch_words_q - 1'b1);
    assign pix_wrap   = (pix_idx == num_pix_q - 1'b1);
    assign first_word = (word_idx == '0);

    a_word_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        {1'b0, word_idx} < ch_words_q);

endmodule

// File: design/weight_buffer.sv
`timescale 1ns/1ns
`include "conv_cfg.svh"

module weight_buffer (
    input  logic                      clk,
    input  logic                      we,
    input  conv_ctrl_pkg::wload_idx_t load_idx,
    input  conv_data_pkg::word_t      w_data,
    input  conv_ctrl_pkg::ch_idx_t    word_idx,
    output conv_data_pkg::pe_weights_t weights
);

    localparam int PE_SEL_W = $clog2(`CONV_NUM_PE);
    localparam int IDX_W    = $bits(conv_ctrl_pkg::wload_idx_t);

    conv_data_pkg::word_t mem [`CONV_NUM_PE][`CONV_MAX_CH_WORDS];

    logic [PE_SEL_W-1:0]    wr_pe;
    conv_ctrl_pkg::ch_idx_t wr_word;

    // Weights arrive PE-interleaved within each channel word
    assign wr_pe   = load_idx[PE_SEL_W-1:0];
    assign wr_word = load_idx[IDX_W-1:PE_SEL_W];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_pe][wr_word] <= w_data;
        end
    end

    always_comb begin
        for (int p = 0; p < `CONV_NUM_PE; p++) begin
            weights[p] = mem[p][word_idx];          // Same channel word for all PEs
        end
    end

endmodule

// File: design/pe_array.sv
`timescale 1ns/1ns
`include "conv_cfg.svh"

module pe_array (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       step,
    input  logic                       first_word,
    input  logic                       last_word,
    input  conv_data_pkg::word_t       ifm_data,
    input  conv_data_pkg::pe_weights_t weights,
    output conv_data_pkg::pe_acc_t     acc,
    output logic                       acc_valid
);

    localparam int LANE_W = `CONV_WORD_W / `CONV_LANES;

    conv_data_pkg::pe_acc_t lane_sum;

    // Dot product of one IFM word with each PE's weight word
    always_comb begin
        logic signed [2*LANE_W-1:0] prod;
        prod     = '0;
        lane_sum = '0;
        for (int p = 0; p < `CONV_NUM_PE; p++) begin
            for (int k = 0; k < `CONV_LANES; k++) begin
                prod = $signed(ifm_data[LANE_W*k +: LANE_W]) *
                       $signed(weights[p][LANE_W*k +: LANE_W]);
                lane_sum[p] = lane_sum[p] + conv_data_pkg::acc_t'(prod);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            for (int p = 0; p < `CONV_NUM_PE; p++) begin
                if (first_word) begin
                    acc[p] <= lane_sum[p];          // New pixel starts fresh
                end else begin
                    acc[p] <= acc[p] + lane_sum[p];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= step && last_word;         // Sum complete next cycle
        end
    end

endmodule

// File: design/ofm_output_stage.sv
`timescale 1ns/1ns
`include "conv_cfg.svh"

module ofm_output_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  conv_data_pkg::pe_acc_t acc,
    input  logic                   acc_valid,
    output logic                   ofm_valid,
    input  logic                   ofm_ready,
    output conv_data_pkg::word_t   ofm_data,
    output logic                   full,
    output logic                   empty
);

    conv_data_pkg::word_t packed_word;
    conv_data_pkg::word_t entry_q [2];
    logic                 wr_ptr;
    logic                 rd_ptr;
    logic [1:0]           count;
    logic                 pop;

    // Shift to Q4 then clamp to [0, 6.0]
    always_comb begin
        conv_data_pkg::acc_t shifted;
        conv_data_pkg::act_t act;
        shifted     = '0;
        act         = '0;
        packed_word = '0;
        for (int p = 0; p < `CONV_NUM_PE; p++) begin
            shifted = $signed(acc[p]) >>> `CONV_OUT_SHIFT;
            if (shifted < 0) begin
                act = '0;
            end else if (shifted > `CONV_RELU6_MAX) begin
                act = conv_data_pkg::act_t'(`CONV_RELU6_MAX);
            end else begin
                act = shifted[7:0];
            end
            packed_word[8*p +: 8] = act;            // PE p to byte p
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            entry_q[wr_ptr] <= packed_word;
        end
    end

    assign pop = ofm_valid && ofm_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (acc_valid) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + {1'b0, acc_valid} - {1'b0, pop};
        end
    end

    assign ofm_valid = (count != 2'd0);
    assign ofm_data  = entry_q[rd_ptr];

    // Count the result still in the PE register
    assign full  = (count == 2'd2) || ((count == 2'd1) && acc_valid);
    assign empty = (count == 2'd0) && !acc_valid;

    a_ofm_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_valid && !ofm_ready |=> ofm_valid && $stable(ofm_data));

    // Upstream stall must keep a third result out
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        acc_valid |-> (count != 2'd2));

endmodule

// File: design/pw_conv_top.sv
`timescale 1ns/1ns
`include "conv_cfg.svh"

module pw_conv_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  conv_ctrl_pkg::ch_cnt_t  ch_words,
    input  conv_ctrl_pkg::pix_cnt_t num_pixels,
    output logic                    busy,
    output logic                    done,
    input  logic                    w_valid,
    output logic                    w_ready,
    input  conv_data_pkg::word_t    w_data,
    input  logic                    ifm_valid,
    output logic                    ifm_ready,
    input  conv_data_pkg::word_t    ifm_data,
    output logic                    ofm_valid,
    input  logic                    ofm_ready,
    output conv_data_pkg::word_t    ofm_data
);

    logic                       cnt_clear;
    logic                       w_step;
    logic                       ifm_step;
    logic                       load_wrap;
    logic                       word_wrap;
    logic                       pix_wrap;
    logic                       first_word;
    logic                       out_full;
    logic                       out_empty;
    logic                       acc_valid;
    conv_ctrl_pkg::wload_idx_t  load_idx;
    conv_ctrl_pkg::ch_idx_t     word_idx;
    conv_data_pkg::pe_weights_t weights;
    conv_data_pkg::pe_acc_t     acc;

    conv_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .ch_words   (ch_words),
        .num_pixels (num_pixels),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .ifm_valid  (ifm_valid),
        .ifm_ready  (ifm_ready),
        .out_full   (out_full),
        .out_empty  (out_empty),
        .load_wrap  (load_wrap),
        .word_wrap  (word_wrap),
        .pix_wrap   (pix_wrap),
        .cnt_clear  (cnt_clear),
        .w_step     (w_step),
        .ifm_step   (ifm_step),
        .busy       (busy),
        .done       (done)
    );

    channel_pixel_counter u_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .ch_words   (ch_words),
        .num_pixels (num_pixels),
        .clear      (cnt_clear),
        .w_step     (w_step),
        .ifm_step   (ifm_step),
        .load_idx   (load_idx),
        .word_idx   (word_idx),
        .first_word (first_word),
        .load_wrap  (load_wrap),
        .word_wrap  (word_wrap),
        .pix_wrap   (pix_wrap)
    );

    weight_buffer u_wbuf (
        .clk      (clk),
        .we       (w_step),
        .load_idx (load_idx),
        .w_data   (w_data),
        .word_idx (word_idx),
        .weights  (weights)
    );

    pe_array u_pe (
        .clk        (clk),
        .rst_n      (rst_n),
        .step       (ifm_step),
        .first_word (first_word),
        .last_word  (word_wrap),                    // Closing word of the pixel
        .ifm_data   (ifm_data),
        .weights    (weights),
        .acc        (acc),
        .acc_valid  (acc_valid)
    );

    ofm_output_stage u_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc       (acc),
        .acc_valid (acc_valid),
        .ofm_valid (ofm_valid),
        .ofm_ready (ofm_ready),
        .ofm_data  (ofm_data),
        .full      (out_full),
        .empty     (out_empty)
    );

endmodule

// File: tb/tb_pw_conv.sv
`timescale 1ns/1ns
`include "conv_cfg.svh"

module tb_pw_conv;

    localparam int WAIT_LIMIT = 2000;                   // Cycles per wait loop

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    conv_ctrl_pkg::ch_cnt_t  ch_words;
    conv_ctrl_pkg::pix_cnt_t num_pixels;
    logic                    busy;
    logic                    done;
    logic                    w_valid;
    logic                    w_ready;
    conv_data_pkg::word_t    w_data;
    logic                    ifm_valid;
    logic                    ifm_ready;
    conv_data_pkg::word_t    ifm_data;
    logic                    ofm_valid;
    logic                    ofm_ready;
    conv_data_pkg::word_t    ofm_data;

    conv_data_pkg::word_t w_mem [64];                   // Load order, PE interleaved
    conv_data_pkg::word_t ifm_mem [$];                  // Pixel major
    conv_data_pkg::word_t exp_q [$];
    conv_data_pkg::word_t got_q [$];
    bit                   backpressure;
    bit                   in_run;
    int                   done_count;

    pw_conv_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .ch_words   (ch_words),
        .num_pixels (num_pixels),
        .busy       (busy),
        .done       (done),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .w_data     (w_data),
        .ifm_valid  (ifm_valid),
        .ifm_ready  (ifm_ready),
        .ifm_data   (ifm_data),
        .ofm_valid  (ofm_valid),
        .ofm_ready  (ofm_ready),
        .ofm_data   (ofm_data)
    );

    always #4 clk = ~clk;

    task automatic report_error(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string name, conv_data_pkg::word_t exp, conv_data_pkg::word_t act);
        if (act !== exp) begin
            report_error($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            report_error($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    function automatic conv_data_pkg::word_t pack_bytes(int b0, int b1, int b2, int b3);
        return {b3[7:0], b2[7:0], b1[7:0], b0[7:0]};
    endfunction

    // Dot product over all channel words, then shift and ReLU6
    function automatic conv_data_pkg::word_t ref_pixel(int chw, int pix);
        conv_data_pkg::word_t res;
        conv_data_pkg::word_t x;
        conv_data_pkg::word_t w;
        int sum;
        int a;
        int b;
        res = '0;
        for (int p = 0; p < `CONV_NUM_PE; p++) begin
            sum = 0;
            for (int c = 0; c < chw; c++) begin
                x = ifm_mem[pix * chw + c];
                w = w_mem[`CONV_NUM_PE * c + p];
                for (int k = 0; k < `CONV_LANES; k++) begin
                    a = $signed(x[8*k +: 8]);
                    b = $signed(w[8*k +: 8]);
                    sum += a * b;
                end
            end
            sum = sum >>> `CONV_OUT_SHIFT;
            if (sum < 0) begin
                sum = 0;
            end else if (sum > `CONV_RELU6_MAX) begin
                sum = `CONV_RELU6_MAX;
            end
            res[8*p +: 8] = sum[7:0];
        end
        return res;
    endfunction

    task automatic fill_random(int chw, int npix);
        for (int i = 0; i < `CONV_NUM_PE * chw; i++) begin
            w_mem[i] = $urandom;
        end
        ifm_mem.delete();
        for (int j = 0; j < chw * npix; j++) begin
            ifm_mem.push_back($urandom);
        end
    endtask

    // Called just after a rising edge, returns on the accepting edge
    task automatic send_weight(conv_data_pkg::word_t d);
        int t;
        t = 0;
        w_valid <= 1'b1;
        w_data  <= d;
        @(negedge clk);
        while (w_ready !== 1'b1) begin
            t++;
            if (t > WAIT_LIMIT) report_error("timeout waiting for w_ready");
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic send_ifm(conv_data_pkg::word_t d);
        int t;
        t = 0;
        ifm_valid <= 1'b1;
        ifm_data  <= d;
        @(negedge clk);
        while (ifm_ready !== 1'b1) begin
            t++;
            if (t > WAIT_LIMIT) report_error("timeout waiting for ifm_ready");
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // One full layer run over w_mem and ifm_mem
    task automatic run_layer(string name, int chw, int npix, bit rand_ready);
        int t;
        exp_q.delete();
        got_q.delete();
        for (int pix = 0; pix < npix; pix++) begin
            exp_q.push_back(ref_pixel(chw, pix));
        end
        backpressure = rand_ready;
        done_count   = 0;
        @(posedge clk);
        start      <= 1'b1;
        ch_words   <= conv_ctrl_pkg::ch_cnt_t'(chw);
        num_pixels <= conv_ctrl_pkg::pix_cnt_t'(npix);
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_flag({name, "_busy_rise"}, 1'b1, busy);   // One cycle after accept
        in_run = 1'b1;
        @(posedge clk);
        for (int i = 0; i < `CONV_NUM_PE * chw; i++) begin
            send_weight(w_mem[i]);
        end
        w_valid <= 1'b0;
        for (int j = 0; j < chw * npix; j++) begin
            send_ifm(ifm_mem[j]);
        end
        ifm_valid <= 1'b0;
        t = 0;
        @(negedge clk);
        while (done !== 1'b1) begin
            t++;
            if (t > WAIT_LIMIT) report_error($sformatf("%s: timeout waiting for done", name));
            @(negedge clk);
        end
        in_run = 1'b0;
        check_flag({name, "_busy_fall"}, 1'b0, busy);
        if (got_q.size() != npix) begin
            report_error($sformatf("%s: %0d output words seen but %0d expected",
                                   name, got_q.size(), npix));
        end
        for (int i = 0; i < npix; i++) begin
            check_word($sformatf("%s_pix%0d", name, i), exp_q[i], got_q[i]);
        end
        repeat (3) @(negedge clk);
        check_flag({name, "_done_once"}, 1'b1, done_count == 1);
    endtask

    task automatic reset_and_single_pixel();
        @(negedge clk);
        check_flag("reset_busy", 1'b0, busy);
        check_flag("reset_done", 1'b0, done);
        check_flag("reset_ofm_valid", 1'b0, ofm_valid);
        check_flag("reset_w_ready", 1'b0, w_ready);
        check_flag("reset_ifm_ready", 1'b0, ifm_ready);
        for (int p = 0; p < `CONV_NUM_PE; p++) begin
            w_mem[p] = pack_bytes(16 * (p + 1), 16, -8, 32);
        end
        ifm_mem.delete();
        ifm_mem.push_back(pack_bytes(1, 2, 3, 4));
        run_layer("single", 1, 1, 1'b0);
    endtask

    task automatic relu6_clamp();
        for (int p = 0; p < `CONV_NUM_PE; p++) begin
            w_mem[p] = pack_bytes(8 * (p + 1), 8 * (p + 1), 8 * (p + 1), 8 * (p + 1));
        end
        ifm_mem.delete();
        ifm_mem.push_back(pack_bytes(-50, -50, -50, -50));  // Negative sums
        ifm_mem.push_back(pack_bytes(127, 127, 127, 127));  // Far above 6.0
        ifm_mem.push_back(pack_bytes(2, 2, 2, 2));          // 64 * (p+1) before shift
        run_layer("relu6", 1, 3, 1'b0);
        check_word("relu6_negative", 32'h0000_0000, got_q[0]);
        check_word("relu6_saturate", pack_bytes(`CONV_RELU6_MAX, `CONV_RELU6_MAX,
                   `CONV_RELU6_MAX, `CONV_RELU6_MAX), got_q[1]);
        check_word("relu6_mid", pack_bytes(4, 8, 12, 16), got_q[2]);
    endtask

    task automatic random_backpressure_run();
        fill_random(4, 20);
        run_layer("random20", 4, 20, 1'b1);
    endtask

    task automatic channel_depth_limits();
        fill_random(16, 3);
        run_layer("depth16", 16, 3, 1'b1);
        fill_random(1, 3);
        run_layer("depth1", 1, 3, 1'b1);
    endtask

    task automatic back_to_back_runs();
        fill_random(2, 4);
        run_layer("first_run", 2, 4, 1'b1);
        fill_random(2, 4);                              // New weights and pixels
        run_layer("second_run", 2, 4, 1'b0);
    endtask

    always @(posedge clk) begin
        ofm_ready <= backpressure ? (($urandom % 2) == 1) : 1'b1;
    end

    always @(negedge clk) begin
        if (ofm_valid === 1'b1 && ofm_ready === 1'b1) begin
            got_q.push_back(ofm_data);                  // Transfer on next edge
        end
        if (done === 1'b1) begin
            done_count++;
        end
        if (in_run && done !== 1'b1 && busy !== 1'b1) begin
            report_error("busy dropped during a run before done");
        end
    end

    initial begin
        void'($urandom(32'hd870_d944));
        clk          = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        ch_words     = conv_ctrl_pkg::ch_cnt_t'(1);
        num_pixels   = conv_ctrl_pkg::pix_cnt_t'(1);
        w_valid      = 1'b0;
        w_data       = '0;
        ifm_valid    = 1'b0;
        ifm_data     = '0;
        ofm_ready    = 1'b0;
        backpressure = 1'b0;
        in_run       = 1'b0;
        done_count   = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        reset_and_single_pixel();
        relu6_clamp();
        random_backpressure_run();
        channel_depth_limits();
        back_to_back_runs();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/conv_data_pkg.sv
design/conv_ctrl_pkg.sv
design/conv_ctrl.sv
design/channel_pixel_counter.sv
design/weight_buffer.sv
design/pe_array.sv
design/ofm_output_stage.sv
design/pw_conv_top.sv
tb/tb_pw_conv.sv
